/* common/irq_pkg.sv */
package irq_pkg;

    // ==================================================
    // widths and basic types
    // ==================================================
    localparam int XLEN       = 32;
    localparam int NUM_SRC    = 31;
    localparam int SRC_ID_W   = 5;
    localparam int PRIO_W     = 3;
    localparam int BUS_ADDR_W = 24;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [SRC_ID_W-1:0]   src_id_t;
    typedef logic [PRIO_W-1:0]     prio_t;
    // bit 0 unused, id 0 means none
    typedef logic [NUM_SRC:0]      src_vec_t;
    typedef prio_t [NUM_SRC:0]     prio_vec_t;
    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

    // ==================================================
    // register addresses
    // ==================================================
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MIE     = 12'h304;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;
    localparam logic [11:0] CSR_MIP     = 12'h344;

    localparam bus_addr_t PLIC_PRIO_BASE = 24'h000000;
    localparam bus_addr_t PLIC_PENDING   = 24'h001000;
    localparam bus_addr_t PLIC_ENABLE    = 24'h002000;
    localparam bus_addr_t PLIC_THRESHOLD = 24'h200000;
    localparam bus_addr_t PLIC_CLAIM     = 24'h200004;

    // mstatus bits, mip/mie bits and cause codes
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int IRQ_MSI = 3;
    localparam int IRQ_MTI = 7;
    localparam int IRQ_MEI = 11;

    // ==================================================
    // structs and enums
    // ==================================================
    typedef struct packed {
        logic      write;
        logic      space;
        bus_addr_t addr;
        word_t     wdata;
    } reg_req_t;

    typedef struct packed {
        word_t pc;
        word_t cause;
    } trap_info_t;

    typedef struct packed {
        logic      re;
        logic      we;
        bus_addr_t addr;
        word_t     wdata;
    } csr_access_t;

    typedef enum logic {
        TRAP_IDLE,
        TRAP_REQ
    } trap_state_e;

endpackage

/* plic/plic_gateway.sv */
module plic_gateway import irq_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  src_vec_t irq_src_i,
    input  logic     claim_i,
    input  src_id_t  claim_id_i,
    input  logic     complete_i,
    input  src_id_t  complete_id_i,
    output src_vec_t pending_o
);

    src_vec_t pending_q;
    src_vec_t in_service_q;
    src_vec_t claim_vec;
    src_vec_t complete_vec;
    src_vec_t valid_mask;

    // id 0 is never a real source
    assign valid_mask   = ~src_vec_t'(1);
    assign claim_vec    = claim_i ? (src_vec_t'(1) << claim_id_i) : '0;
    assign complete_vec = complete_i ? (src_vec_t'(1) << complete_id_i) : '0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            // level line is latched once, then blocked until complete
            pending_q    <= (pending_q | (irq_src_i & ~in_service_q)) & ~claim_vec & valid_mask;
            in_service_q <= (in_service_q | claim_vec) & ~complete_vec & valid_mask;
        end
    end

    assign pending_o = pending_q;

endmodule

/* plic/plic_arbiter.sv */
module plic_arbiter import irq_pkg::*; (
    input  src_vec_t  pending_i,
    input  src_vec_t  enable_i,
    input  prio_vec_t prio_i,
    input  prio_t     threshold_i,
    output src_id_t   best_id_o,
    output logic      meip_o
);

    src_id_t best_id;
    prio_t   best_prio;

    // strict compare keeps the lower id on ties
    always_comb begin
        best_id   = '0;
        best_prio = threshold_i;
        for (int i = 1; i <= NUM_SRC; i++) begin
            if (pending_i[i] && enable_i[i] && (prio_i[i] > best_prio)) begin
                best_id   = src_id_t'(i);
                best_prio = prio_i[i];
            end
        end
    end

    assign best_id_o = best_id;
    assign meip_o    = (best_id != '0);

endmodule

/* plic/plic_regs.sv */
module plic_regs import irq_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  csr_access_t acc_i,
    input  src_vec_t    pending_i,
    input  src_id_t     best_id_i,
    output word_t       rdata_o,
    output prio_vec_t   prio_o,
    output src_vec_t    enable_o,
    output prio_t       threshold_o,
    output logic        claim_o,
    output logic        complete_o,
    output src_id_t     complete_id_o
);

    prio_vec_t prio_q;
    src_vec_t  enable_q;
    prio_t     threshold_q;

    src_id_t   prio_idx;
    logic      prio_hit;
    logic      is_claim;

    // ==================================================
    // address decode
    // ==================================================
    // priority words sit at base + 4*id
    assign prio_idx = acc_i.addr[SRC_ID_W+1:2];
    assign prio_hit = (acc_i.addr[BUS_ADDR_W-1:SRC_ID_W+2] ==
                       PLIC_PRIO_BASE[BUS_ADDR_W-1:SRC_ID_W+2])
                   && (acc_i.addr[1:0] == 2'b00)
                   && (prio_idx != '0);
    assign is_claim = (acc_i.addr == PLIC_CLAIM);

    // ==================================================
    // configuration registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            prio_q      <= '0;
            enable_q    <= '0;
            threshold_q <= '0;
        end else if (acc_i.we) begin
            if (prio_hit) begin
                prio_q[prio_idx] <= acc_i.wdata[PRIO_W-1:0];
            end else if (acc_i.addr == PLIC_ENABLE) begin
                enable_q <= src_vec_t'(acc_i.wdata) & ~src_vec_t'(1);
            end else if (acc_i.addr == PLIC_THRESHOLD) begin
                threshold_q <= acc_i.wdata[PRIO_W-1:0];
            end
        end
    end

    // read mux, unmapped reads return zero
    always_comb begin
        rdata_o = '0;
        if (prio_hit) begin
            rdata_o = word_t'(prio_q[prio_idx]);
        end else begin
            case (acc_i.addr)
                PLIC_PENDING:   rdata_o = word_t'(pending_i);
                PLIC_ENABLE:    rdata_o = word_t'(enable_q);
                PLIC_THRESHOLD: rdata_o = word_t'(threshold_q);
                PLIC_CLAIM:     rdata_o = word_t'(best_id_i);
                default:        rdata_o = '0;
            endcase
        end
    end

    // claim on read, complete on write
    assign claim_o       = acc_i.re & is_claim;
    assign complete_o    = acc_i.we & is_claim;
    assign complete_id_o = acc_i.wdata[SRC_ID_W-1:0];

    assign prio_o      = prio_q;
    assign enable_o    = enable_q;
    assign threshold_o = threshold_q;

endmodule

/* csr/csr_file.sv */
module csr_file import irq_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  csr_access_t acc_i,
    input  logic        meip_i,
    input  logic        timer_irq_i,
    input  logic        soft_irq_i,
    input  logic        trap_take_i,
    input  word_t       trap_pc_i,
    input  word_t       trap_cause_i,
    input  logic        mret_i,
    output word_t       rdata_o,
    output word_t       mstatus_o,
    output word_t       mie_o,
    output word_t       mip_o,
    output word_t       mtvec_o
);

    word_t mstatus_q;
    word_t mie_q;
    word_t mtvec_q;
    word_t mepc_q;
    word_t mcause_q;
    word_t mip;

    // mip is read-only, straight from the interrupt lines
    always_comb begin
        mip          = '0;
        mip[IRQ_MEI] = meip_i;
        mip[IRQ_MTI] = timer_irq_i;
        mip[IRQ_MSI] = soft_irq_i;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mstatus_q <= '0;
            mie_q     <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else begin
            if (acc_i.we) begin
                case (acc_i.addr)
                    bus_addr_t'(CSR_MSTATUS): mstatus_q <= acc_i.wdata;
                    bus_addr_t'(CSR_MIE):     mie_q     <= acc_i.wdata;
                    bus_addr_t'(CSR_MTVEC):   mtvec_q   <= acc_i.wdata;
                    bus_addr_t'(CSR_MEPC):    mepc_q    <= acc_i.wdata;
                    bus_addr_t'(CSR_MCAUSE):  mcause_q  <= acc_i.wdata;
                    default: ;
                endcase
            end
            // trap entry and mret override a bus write
            if (trap_take_i) begin
                mepc_q                      <= trap_pc_i;
                mcause_q                    <= trap_cause_i;
                mstatus_q[MSTATUS_MPIE_BIT] <= mstatus_q[MSTATUS_MIE_BIT];
                mstatus_q[MSTATUS_MIE_BIT]  <= 1'b0;
            end else if (mret_i) begin
                mstatus_q[MSTATUS_MIE_BIT]  <= mstatus_q[MSTATUS_MPIE_BIT];
                mstatus_q[MSTATUS_MPIE_BIT] <= 1'b1;
            end
        end
    end

    always_comb begin
        case (acc_i.addr)
            bus_addr_t'(CSR_MSTATUS): rdata_o = mstatus_q;
            bus_addr_t'(CSR_MIE):     rdata_o = mie_q;
            bus_addr_t'(CSR_MTVEC):   rdata_o = mtvec_q;
            bus_addr_t'(CSR_MEPC):    rdata_o = mepc_q;
            bus_addr_t'(CSR_MCAUSE):  rdata_o = mcause_q;
            bus_addr_t'(CSR_MIP):     rdata_o = mip;
            default:                  rdata_o = '0;
        endcase
    end

    assign mstatus_o = mstatus_q;
    assign mie_o     = mie_q;
    assign mip_o     = mip;
    assign mtvec_o   = mtvec_q;

endmodule

/* csr/trap_ctrl.sv */
module trap_ctrl import irq_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  word_t      mstatus_i,
    input  word_t      mie_i,
    input  word_t      mip_i,
    input  word_t      mtvec_i,
    input  logic       commit_valid_i,
    input  word_t      commit_pc_i,
    input  logic       mret_i,
    input  logic       trap_ready_i,
    output logic       trap_valid_o,
    output trap_info_t trap_o,
    output logic       trap_take_o,
    output word_t      epc_o
);

    trap_state_e state_q;
    trap_info_t  trap_q;
    word_t       epc_q;
    word_t       enabled;
    word_t       cause;
    logic        take_irq;

    assign enabled  = mip_i & mie_i;
    assign take_irq = commit_valid_i && !mret_i && mstatus_i[MSTATUS_MIE_BIT]
                   && (enabled != '0) && (state_q == TRAP_IDLE);

    // external first, then software, then timer
    always_comb begin
        cause = '0;
        if (enabled[IRQ_MEI]) begin
            cause = word_t'(IRQ_MEI);
        end else if (enabled[IRQ_MSI]) begin
            cause = word_t'(IRQ_MSI);
        end else begin
            cause = word_t'(IRQ_MTI);
        end
        cause[XLEN-1] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= TRAP_IDLE;
        end else begin
            case (state_q)
                TRAP_IDLE: if (take_irq) state_q <= TRAP_REQ;
                TRAP_REQ:  if (trap_ready_i) state_q <= TRAP_IDLE;
                default:   state_q <= TRAP_IDLE;
            endcase
        end
    end

    // request payload, held until the handshake
    always_ff @(posedge clk) begin
        if (take_irq) begin
            trap_q.pc    <= {mtvec_i[XLEN-1:2], 2'b00};
            trap_q.cause <= cause;
            epc_q        <= commit_pc_i;
        end
    end

    assign trap_valid_o = (state_q == TRAP_REQ);
    assign trap_o       = trap_q;
    assign trap_take_o  = trap_valid_o & trap_ready_i;
    assign epc_o        = epc_q;

endmodule

/* verilog/irq_bus_mux.sv */
module irq_bus_mux import irq_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        req_valid_i,
    input  reg_req_t    req_i,
    input  logic        rsp_ready_i,
    input  word_t       csr_rdata_i,
    input  word_t       plic_rdata_i,
    output logic        req_ready_o,
    output logic        rsp_valid_o,
    output word_t       rsp_rdata_o,
    output csr_access_t csr_acc_o,
    output csr_access_t plic_acc_o
);

    logic  rsp_valid_q;
    word_t rsp_rdata_q;
    logic  accept;

    // one response slot, no new request while it is full
    assign req_ready_o = !rsp_valid_q;
    assign accept      = req_valid_i && req_ready_o;

    always_comb begin
        csr_acc_o.re     = accept && !req_i.write && !req_i.space;
        csr_acc_o.we     = accept && req_i.write && !req_i.space;
        csr_acc_o.addr   = req_i.addr;
        csr_acc_o.wdata  = req_i.wdata;
        plic_acc_o.re    = accept && !req_i.write && req_i.space;
        plic_acc_o.we    = accept && req_i.write && req_i.space;
        plic_acc_o.addr  = req_i.addr;
        plic_acc_o.wdata = req_i.wdata;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rsp_valid_q <= 1'b0;
        end else if (accept) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // writes answer with zero
    always_ff @(posedge clk) begin
        if (accept) begin
            if (req_i.write) begin
                rsp_rdata_q <= '0;
            end else begin
                rsp_rdata_q <= req_i.space ? plic_rdata_i : csr_rdata_i;
            end
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_rdata_o = rsp_rdata_q;

endmodule

/* verilog/mcu_irq_top.sv */
module mcu_irq_top import irq_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       req_valid_i,
    output logic       req_ready_o,
    input  reg_req_t   req_i,
    output logic       rsp_valid_o,
    input  logic       rsp_ready_i,
    output word_t      rsp_rdata_o,
    input  src_vec_t   irq_src_i,
    input  logic       timer_irq_i,
    input  logic       soft_irq_i,
    input  logic       commit_valid_i,
    input  word_t      commit_pc_i,
    input  logic       mret_i,
    output logic       trap_valid_o,
    input  logic       trap_ready_i,
    output trap_info_t trap_o
);

    // ==================================================
    // interconnect
    // ==================================================
    csr_access_t csr_acc;
    csr_access_t plic_acc;
    word_t       csr_rdata;
    word_t       plic_rdata;
    src_vec_t    pending;
    src_vec_t    enable;
    prio_vec_t   prio;
    prio_t       threshold;
    src_id_t     best_id;
    src_id_t     complete_id;
    logic        meip;
    logic        claim;
    logic        complete;
    word_t       mstatus;
    word_t       mie;
    word_t       mip;
    word_t       mtvec;
    word_t       trap_epc;
    logic        trap_take;

    irq_bus_mux u_bus_mux (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .rsp_ready_i  (rsp_ready_i),
        .csr_rdata_i  (csr_rdata),
        .plic_rdata_i (plic_rdata),
        .req_ready_o  (req_ready_o),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_rdata_o  (rsp_rdata_o),
        .csr_acc_o    (csr_acc),
        .plic_acc_o   (plic_acc)
    );

    plic_regs u_plic_regs (
        .clk           (clk),
        .resetn        (resetn),
        .acc_i         (plic_acc),
        .pending_i     (pending),
        .best_id_i     (best_id),
        .rdata_o       (plic_rdata),
        .prio_o        (prio),
        .enable_o      (enable),
        .threshold_o   (threshold),
        .claim_o       (claim),
        .complete_o    (complete),
        .complete_id_o (complete_id)
    );

    plic_gateway u_plic_gateway (
        .clk           (clk),
        .resetn        (resetn),
        .irq_src_i     (irq_src_i),
        .claim_i       (claim),
        .claim_id_i    (best_id),
        .complete_i    (complete),
        .complete_id_i (complete_id),
        .pending_o     (pending)
    );

    plic_arbiter u_plic_arbiter (
        .pending_i   (pending),
        .enable_i    (enable),
        .prio_i      (prio),
        .threshold_i (threshold),
        .best_id_o   (best_id),
        .meip_o      (meip)
    );

    csr_file u_csr_file (
        .clk          (clk),
        .resetn       (resetn),
        .acc_i        (csr_acc),
        .meip_i       (meip),
        .timer_irq_i  (timer_irq_i),
        .soft_irq_i   (soft_irq_i),
        .trap_take_i  (trap_take),
        .trap_pc_i    (trap_epc),
        .trap_cause_i (trap_o.cause),
        .mret_i       (commit_valid_i & mret_i),
        .rdata_o      (csr_rdata),
        .mstatus_o    (mstatus),
        .mie_o        (mie),
        .mip_o        (mip),
        .mtvec_o      (mtvec)
    );

    trap_ctrl u_trap_ctrl (
        .clk            (clk),
        .resetn         (resetn),
        .mstatus_i      (mstatus),
        .mie_i          (mie),
        .mip_i          (mip),
        .mtvec_i        (mtvec),
        .commit_valid_i (commit_valid_i),
        .commit_pc_i    (commit_pc_i),
        .mret_i         (mret_i),
        .trap_ready_i   (trap_ready_i),
        .trap_valid_o   (trap_valid_o),
        .trap_o         (trap_o),
        .trap_take_o    (trap_take),
        .epc_o          (trap_epc)
    );

endmodule

/* dv/tb_irq_tasks.svh */
`ifndef TB_IRQ_TASKS_SVH
`define TB_IRQ_TASKS_SVH

word_t rng_state = 32'd8;

// xorshift32 with a fixed seed
function automatic word_t xorshift32();
    word_t x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// one bus transfer with the response captured the cycle after acceptance
task automatic bus_access(input logic write, input logic space, input bus_addr_t addr,
                          input word_t wdata, output word_t rdata);
    @(negedge clk);
    req_valid_i = 1'b1;
    req_i.write = write;
    req_i.space = space;
    req_i.addr  = addr;
    req_i.wdata = wdata;
    while (!req_ready_o) begin
        @(negedge clk);
    end
    @(negedge clk);
    req_valid_i = 1'b0;
    assert (rsp_valid_o === 1'b1) else begin
        $display("[ERROR] test=%s no response one cycle after acceptance", test_name);
        abort_run();
    end
    rdata = rsp_rdata_o;
    // writes answer with zero data
    if (write) begin
        check_value("write response", 32'd0, rdata);
    end
endtask

task automatic csr_write(input logic [11:0] addr, input word_t wdata);
    word_t unused;
    bus_access(1'b1, SPACE_CSR, bus_addr_t'(addr), wdata, unused);
endtask

task automatic plic_write(input bus_addr_t addr, input word_t wdata);
    word_t unused;
    bus_access(1'b1, SPACE_PLIC, addr, wdata, unused);
endtask

task automatic csr_expect(input logic [11:0] addr, input word_t exp, input string what);
    word_t data;
    bus_access(1'b0, SPACE_CSR, bus_addr_t'(addr), '0, data);
    check_value(what, exp, data);
endtask

task automatic plic_expect(input bus_addr_t addr, input word_t exp, input string what);
    word_t data;
    bus_access(1'b0, SPACE_PLIC, addr, '0, data);
    check_value(what, exp, data);
endtask

// retire one instruction on the commit port
task automatic retire(input word_t pc, input logic is_mret);
    @(negedge clk);
    commit_valid_i = 1'b1;
    commit_pc_i    = pc;
    mret_i         = is_mret;
    @(negedge clk);
    commit_valid_i = 1'b0;
    mret_i         = 1'b0;
endtask

// hold off the trap for a few cycles, then take it
task automatic accept_trap(input word_t exp_pc, input word_t exp_cause, input int stall);
    for (int i = 0; i <= stall; i++) begin
        check_value("trap valid", 32'd1, word_t'(trap_valid_o));
        check_value("trap target", exp_pc, trap_o.pc);
        check_value("trap cause", exp_cause, trap_o.cause);
        if (i == stall) begin
            trap_ready_i = 1'b1;
        end
        @(negedge clk);
    end
    trap_ready_i = 1'b0;
    check_value("trap valid after accept", 32'd0, word_t'(trap_valid_o));
endtask

`endif

/* dv/tb_mcu_irq.sv */
module tb_mcu_irq import irq_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // a few times the length of the whole sequence
    localparam int   TIMEOUT_CYCLES = 4000;
    localparam logic SPACE_CSR      = 1'b0;
    localparam logic SPACE_PLIC     = 1'b1;
    localparam word_t TVEC          = 32'h0000_2000;

    logic       clk = 1'b0;
    logic       resetn;
    logic       req_valid_i;
    logic       req_ready_o;
    reg_req_t   req_i;
    logic       rsp_valid_o;
    logic       rsp_ready_i;
    word_t      rsp_rdata_o;
    src_vec_t   irq_src_i;
    logic       timer_irq_i;
    logic       soft_irq_i;
    logic       commit_valid_i;
    word_t      commit_pc_i;
    logic       mret_i;
    logic       trap_valid_o;
    logic       trap_ready_i;
    trap_info_t trap_o;

    string    test_name = "reset";
    int       cycle_count = 0;
    int       prio_model [NUM_SRC+1];
    src_vec_t raised;
    src_vec_t en_mask;
    int       thr;
    int       src;

    always #10 clk = ~clk;

    mcu_irq_top DUT (.*);

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string what, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("[ERROR] test=%s %s expected=0x%08h actual=0x%08h",
                     test_name, what, exp, act);
            abort_run();
        end
    endtask

    // highest priority above threshold, then lowest id among those
    function automatic int expected_winner(input src_vec_t cand, input int limit);
        int top;
        top = limit;
        for (int id = 1; id <= NUM_SRC; id++) begin
            if (cand[id] && prio_model[id] > top) begin
                top = prio_model[id];
            end
        end
        for (int id = 1; id <= NUM_SRC; id++) begin
            if (top > limit && cand[id] && prio_model[id] == top) begin
                return id;
            end
        end
        return 0;
    endfunction

    `include "tb_irq_tasks.svh"

    // ==================================================
    // protocol checks
    // ==================================================
    rsp_after_accept: assert property (
        @(posedge clk) disable iff (!resetn)
        (req_valid_i && req_ready_o) |=> rsp_valid_o
    ) else begin
        $display("[ERROR] test=%s response missing one cycle after acceptance", test_name);
        abort_run();
    end

    ready_while_held: assert property (
        @(posedge clk) disable iff (!resetn)
        rsp_valid_o |-> !req_ready_o
    ) else begin
        $display("[ERROR] test=%s request ready while a response was still held", test_name);
        abort_run();
    end

    trap_held: assert property (
        @(posedge clk) disable iff (!resetn)
        (trap_valid_o && !trap_ready_i) |=> (trap_valid_o && $stable(trap_o))
    ) else begin
        $display("[ERROR] test=%s trap request changed before it was accepted", test_name);
        abort_run();
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: test %s did not finish within %0d cycles",
                     test_name, TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        resetn         = 1'b0;
        req_valid_i    = 1'b0;
        req_i          = '0;
        rsp_ready_i    = 1'b1;
        irq_src_i      = '0;
        timer_irq_i    = 1'b0;
        soft_irq_i     = 1'b0;
        commit_valid_i = 1'b0;
        commit_pc_i    = '0;
        mret_i         = 1'b0;
        trap_ready_i   = 1'b0;
        repeat (8) @(negedge clk);
        resetn = 1'b1;

        test_name = "csr_access";
        csr_write(CSR_MTVEC, 32'h8000_0104);
        csr_expect(CSR_MTVEC, 32'h8000_0104, "mtvec");
        csr_write(CSR_MIE, 32'h0000_0888);
        csr_expect(CSR_MIE, 32'h0000_0888, "mie");
        csr_write(CSR_MSTATUS, 32'h0000_0088);
        csr_expect(CSR_MSTATUS, 32'h0000_0088, "mstatus");
        csr_write(CSR_MSTATUS, 32'h0);
        csr_write(CSR_MIP, 32'hffff_ffff);
        timer_irq_i = 1'b1;
        csr_expect(CSR_MIP, 32'h0000_0080, "mip timer");
        timer_irq_i = 1'b0;
        soft_irq_i  = 1'b1;
        csr_expect(CSR_MIP, 32'h0000_0008, "mip soft");
        soft_irq_i  = 1'b0;

        test_name = "arbitration";
        // lines 1 to 15 held high
        raised    = src_vec_t'(32'h0000_fffe);
        irq_src_i = raised;
        for (int round = 0; round < 6; round++) begin
            for (int id = 1; id <= NUM_SRC; id++) begin
                // round 4 gives every source the same priority
                prio_model[id] = (round == 4) ? 6 : xorshift32() % 8;
                plic_write(bus_addr_t'(PLIC_PRIO_BASE + 4 * id), prio_model[id]);
            end
            en_mask = src_vec_t'(xorshift32()) & ~src_vec_t'(1);
            // last round sets the top threshold so nothing can win
            thr = (round == 5) ? 7 : xorshift32() % 4;
            plic_write(PLIC_ENABLE, en_mask);
            plic_write(PLIC_THRESHOLD, thr);
            plic_expect(PLIC_PENDING, raised, "pending");
            src = expected_winner(raised & en_mask, thr);
            plic_expect(PLIC_CLAIM, src, "claim id");
            if (src != 0) begin
                plic_write(PLIC_CLAIM, src);
            end
        end
        irq_src_i = '0;

        test_name = "claim_complete";
        src = 16 + xorshift32() % 16;
        plic_write(PLIC_ENABLE, 32'd1 << src);
        plic_write(bus_addr_t'(PLIC_PRIO_BASE + 4 * src), 5);
        plic_write(PLIC_THRESHOLD, 0);
        irq_src_i[src] = 1'b1;
        plic_expect(PLIC_PENDING, raised | (32'd1 << src), "pending before claim");
        plic_expect(PLIC_CLAIM, src, "first claim");
        plic_expect(PLIC_PENDING, raised, "pending while in service");
        plic_expect(PLIC_CLAIM, 0, "second claim");
        plic_write(PLIC_CLAIM, src);
        plic_expect(PLIC_PENDING, raised | (32'd1 << src), "pending after complete");
        plic_expect(PLIC_CLAIM, src, "claim after complete");
        irq_src_i[src] = 1'b0;
        plic_write(PLIC_CLAIM, src);

        test_name = "external_trap";
        plic_write(bus_addr_t'(PLIC_PRIO_BASE + 4 * src), 1);
        csr_write(CSR_MTVEC, TVEC | 32'd1);
        csr_write(CSR_MIE, 32'd1 << IRQ_MEI);
        csr_write(CSR_MSTATUS, 32'd1 << MSTATUS_MIE_BIT);
        irq_src_i[src] = 1'b1;
        csr_expect(CSR_MIP, 32'd1 << IRQ_MEI, "mip external");
        retire(32'h0000_0440, 1'b0);
        accept_trap(TVEC, 32'h8000_000b, 0);
        csr_expect(CSR_MEPC, 32'h0000_0440, "mepc");
        csr_expect(CSR_MCAUSE, 32'h8000_000b, "mcause");
        csr_expect(CSR_MSTATUS, 32'd1 << MSTATUS_MPIE_BIT, "mstatus after entry");
        plic_expect(PLIC_CLAIM, src, "claim in handler");
        irq_src_i[src] = 1'b0;
        plic_write(PLIC_CLAIM, src);

        test_name = "local_causes";
        csr_write(CSR_MIE, (32'd1 << IRQ_MSI) | (32'd1 << IRQ_MTI));
        csr_write(CSR_MSTATUS, 32'd1 << MSTATUS_MIE_BIT);
        soft_irq_i  = 1'b1;
        timer_irq_i = 1'b1;
        retire(32'h0000_0500, 1'b0);
        accept_trap(TVEC, 32'h8000_0003, 1 + xorshift32() % 8);
        csr_write(CSR_MSTATUS, 32'd1 << MSTATUS_MIE_BIT);
        soft_irq_i = 1'b0;
        retire(32'h0000_0504, 1'b0);
        accept_trap(TVEC, 32'h8000_0007, 1 + xorshift32() % 8);
        csr_expect(CSR_MEPC, 32'h0000_0504, "mepc timer");
        timer_irq_i = 1'b0;

        test_name = "mret";
        // timer already pending when the mret retires
        timer_irq_i = 1'b1;
        retire(32'h0000_0600, 1'b1);
        check_value("trap on mret", 32'd0, word_t'(trap_valid_o));
        csr_expect(CSR_MSTATUS, 32'h0000_0088, "mstatus after mret");
        retire(32'h0000_0608, 1'b0);
        accept_trap(TVEC, 32'h8000_0007, 0);
        csr_expect(CSR_MEPC, 32'h0000_0608, "mepc after mret");
        timer_irq_i = 1'b0;

        $display("Testbench passed");
        $finish;
    end

endmodule

/* sim.f */
+incdir+dv
common/irq_pkg.sv
plic/plic_gateway.sv
plic/plic_arbiter.sv
plic/plic_regs.sv
csr/csr_file.sv
csr/trap_ctrl.sv
verilog/irq_bus_mux.sv
verilog/mcu_irq_top.sv
dv/tb_mcu_irq.sv

/* Bender.yml */
package:
  name: mcu_irq

sources:
  - common/irq_pkg.sv
  - plic/plic_gateway.sv
  - plic/plic_arbiter.sv
  - plic/plic_regs.sv
  - csr/csr_file.sv
  - csr/trap_ctrl.sv
  - verilog/irq_bus_mux.sv
  - verilog/mcu_irq_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_mcu_irq.sv
